/* logic/xgmii_rx_pkg.sv */
package xgmii_rx_pkg;

	////////////////////////////////////////////////////////////
	// XGMII control characters and frame constants

	localparam logic [7:0] xgmii_ctl_start = 8'hfb;
	localparam logic [7:0] xgmii_ctl_end   = 8'hfd;
	localparam logic [7:0] xgmii_ctl_error = 8'hfe;
	localparam logic [7:0] xgmii_ctl_idle  = 8'h07;

	// Three preamble bytes then the SFD, lane 3 first
	localparam logic [31:0] preamble_sfd_word = 32'h555555d5;

	// Byte lanes per XGMII word
	localparam int lane_count = 4;

	////////////////////////////////////////////////////////////
	// Bus structs

	// Word from the PCS, lane 3 is the high byte and goes first
	typedef struct packed {
		logic                    valid;
		logic [lane_count-1:0]   ctl;
		logic [8*lane_count-1:0] data;
	} xgmii_word_t;

	// Stream to the upper layer
	// Do not act on the data until commit
	typedef struct packed {
		logic        start;
		logic        data_valid;
		logic [2:0]  bytes_valid;
		logic [31:0] data;
		logic        commit;
		logic        drop;
	} eth_rx_bus_t;

	// Frame boundary events toward the FCS checker
	typedef struct packed {
		logic       frame_end;
		logic       frame_abort;
		// FCS bytes that spill into the end word
		logic [1:0] fcs_offset;
	} frame_event_t;

	// Receive FSM states
	typedef enum logic [1:0] {
		state_idle     = 2'd0,
		state_preamble = 2'd1,
		state_body     = 2'd2
	} rx_state_t;

endpackage

/* logic/rx_frame_fsm.sv */
`timescale 1ns/1ps

module rx_frame_fsm (
	input  logic                       xgmii_rx_clk,
	input  logic                       rst_n,
	input  xgmii_rx_pkg::xgmii_word_t  xgmii_rx_bus,
	output xgmii_rx_pkg::eth_rx_bus_t  rx_stream,
	output xgmii_rx_pkg::frame_event_t frame_event,
	output logic                       crc_restart
);

	import xgmii_rx_pkg::*;

	rx_state_t             rx_state;
	logic                  last_was_preamble;
	logic                  start_q;
	logic [31:0]           data_q;
	logic [lane_count-1:0] lane_has_end;
	logic [lane_count-1:0] lane_has_error;
	logic                  sof_seen;
	logic                  preamble_ok;
	logic [2:0]            tail_bytes;
	logic [1:0]            fcs_offset;
	logic                  data_valid;
	logic [2:0]            bytes_valid;
	logic                  frame_end;
	logic                  frame_abort;

	////////////////////////////////////////////////////////////
	// Lane decoding

	// Lane i sits in byte i of the word
	for (genvar i = 0; i < lane_count; i++) begin : g_lane
		assign lane_has_end[i] = xgmii_rx_bus.ctl[i] &&
			(xgmii_rx_bus.data[8*i +: 8] == xgmii_ctl_end);
		assign lane_has_error[i] = xgmii_rx_bus.ctl[i] &&
			(xgmii_rx_bus.data[8*i +: 8] == xgmii_ctl_error);
	end

	// Start character is only legal in the first lane
	assign sof_seen = xgmii_rx_bus.ctl[lane_count-1] &&
		(xgmii_rx_bus.data[31:24] == xgmii_ctl_start);

	// Exactly one preamble word, all data, no control flags
	assign preamble_ok = (xgmii_rx_bus.ctl == '0) &&
		(xgmii_rx_bus.data == preamble_sfd_word);

	// Data bytes left in the registered word, by end lane
	// FCS is the four bytes just before the end character
	always_comb begin
		tail_bytes = 3'd4;
		fcs_offset = 2'd0;
		if (lane_has_end[3]) begin
			// Whole previous word was FCS
			tail_bytes = 3'd0;
			fcs_offset = 2'd0;
		end else if (lane_has_end[2]) begin
			tail_bytes = 3'd1;
			fcs_offset = 2'd1;
		end else if (lane_has_end[1]) begin
			tail_bytes = 3'd2;
			fcs_offset = 2'd2;
		end else if (lane_has_end[0]) begin
			tail_bytes = 3'd3;
			fcs_offset = 2'd3;
		end
	end

	////////////////////////////////////////////////////////////
	// Stream qualifiers and frame events

	// Output word is always the previous valid beat
	always_comb begin
		data_valid  = 1'b0;
		bytes_valid = 3'd0;
		frame_end   = 1'b0;
		frame_abort = 1'b0;
		if (xgmii_rx_bus.valid && (rx_state != state_idle)) begin
			// Error anywhere in a frame kills it
			if (|lane_has_error) begin
				frame_abort = 1'b1;
			end else if (rx_state == state_body) begin
				frame_end = |lane_has_end;
				// Registered word is the preamble, never upward
				if (!last_was_preamble)
					bytes_valid = tail_bytes;
				data_valid = (bytes_valid != 3'd0);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Receive FSM

	always_ff @(posedge xgmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_state          <= state_idle;
			last_was_preamble <= 1'b0;
			start_q           <= 1'b0;
		end else begin
			// Start is a single clock strobe
			start_q <= 1'b0;
			if (xgmii_rx_bus.valid) begin
				last_was_preamble <= 1'b0;
				case (rx_state)
					state_idle: begin
						// Idles and stray errors are ignored here
						if (sof_seen)
							rx_state <= state_preamble;
					end
					state_preamble: begin
						last_was_preamble <= 1'b1;
						if (preamble_ok) begin
							rx_state <= state_body;
							start_q  <= 1'b1;
						end else begin
							rx_state <= state_idle;
						end
					end
					state_body: begin
						// End may land in any lane
						if (|lane_has_end)
							rx_state <= state_idle;
					end
					default: rx_state <= state_idle;
				endcase
				// Abort wins over everything above
				if (frame_abort)
					rx_state <= state_idle;
			end
		end
	end

	// Data word register, frozen while valid is low
	always_ff @(posedge xgmii_rx_clk) begin
		if (xgmii_rx_bus.valid)
			data_q <= xgmii_rx_bus.data;
	end

	// CRC reseeds on start, before the first body byte
	assign crc_restart = start_q;

	assign frame_event = '{
		frame_end:   frame_end,
		frame_abort: frame_abort,
		fcs_offset:  fcs_offset
	};

	assign rx_stream = '{
		start:       start_q,
		data_valid:  data_valid,
		bytes_valid: bytes_valid,
		data:        data_q,
		commit:      1'b0,
		drop:        1'b0
	};

endmodule

/* logic/crc32_eth_x32.sv */
`timescale 1ns/1ps

module crc32_eth_x32 #(
	parameter int crc_latency = 2
) (
	input  logic        xgmii_rx_clk,
	input  logic        rst_n,
	input  logic        enable,
	input  logic        restart,
	input  logic [31:0] din,
	input  logic [2:0]  din_len,
	output logic [31:0] crc_value
);

	// Reflected Ethernet polynomial
	localparam logic [31:0] crc_poly  = 32'hedb88320;
	localparam logic [31:0] crc_seed  = 32'hffffffff;
	// Stages ahead of the running register, latency 2 or more
	localparam int          pipe_depth = crc_latency - 1;

	logic [31:0] data_term [pipe_depth];
	logic [2:0]  len_pipe [pipe_depth];
	logic [31:0] crc_reg;

	// Byte-serial reflected CRC over the len high bytes of data
	function automatic logic [31:0] crc_step(
		input logic [31:0] crc_in,
		input logic [31:0] data,
		input logic [2:0]  len
	);
		logic [31:0] crc;
		crc = crc_in;
		for (int i = 0; i < 4; i++) begin
			if (i < len) begin
				crc = crc ^ {24'h0, data[31-8*i -: 8]};
				for (int j = 0; j < 8; j++)
					crc = crc[0] ? ((crc >> 1) ^ crc_poly) : (crc >> 1);
			end
		end
		return crc;
	endfunction

	////////////////////////////////////////////////////////////
	// Split update
	// The step is linear, so the data term is folded in first
	// and the state term is applied in the last stage

	always_ff @(posedge xgmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < pipe_depth; i++) begin
				data_term[i] <= 32'h0;
				len_pipe[i]  <= 3'd0;
			end
			crc_reg <= crc_seed;
		end else begin
			if (enable) begin
				// Data only contribution, zero initial state
				data_term[0] <= crc_step(32'h0, din, din_len);
				len_pipe[0]  <= din_len;
				for (int i = 1; i < pipe_depth; i++) begin
					data_term[i] <= data_term[i-1];
					len_pipe[i]  <= len_pipe[i-1];
				end
			end
			// Reseed independent of enable
			if (restart)
				crc_reg <= crc_seed;
			else if (enable)
				crc_reg <= crc_step(crc_reg, 32'h0, len_pipe[pipe_depth-1]) ^
					data_term[pipe_depth-1];
		end
	end

	// Final inversion, first FCS byte on the wire in the high byte
	assign crc_value = ~{crc_reg[7:0], crc_reg[15:8], crc_reg[23:16], crc_reg[31:24]};

endmodule

/* logic/fcs_checker.sv */
`timescale 1ns/1ps

module fcs_checker #(
	parameter int crc_latency = 2
) (
	input  logic                       xgmii_rx_clk,
	input  logic                       rst_n,
	input  xgmii_rx_pkg::xgmii_word_t  xgmii_rx_bus,
	input  logic [31:0]                prev_data,
	input  xgmii_rx_pkg::frame_event_t frame_event,
	input  logic [31:0]                crc_value,
	output logic                       commit,
	output logic                       drop
);

	logic [31:0]            fcs_expected;
	logic [31:0]            fcs_pipe [crc_latency];
	logic [crc_latency-1:0] pending;

	////////////////////////////////////////////////////////////
	// Expected FCS from the last two words

	// Wire order, first FCS byte in the high byte
	always_comb begin
		case (frame_event.fcs_offset)
			2'd1:    fcs_expected = {prev_data[23:0], xgmii_rx_bus.data[31:24]};
			2'd2:    fcs_expected = {prev_data[15:0], xgmii_rx_bus.data[31:16]};
			2'd3:    fcs_expected = {prev_data[7:0], xgmii_rx_bus.data[31:8]};
			// End in lane 3, previous word is all FCS
			default: fcs_expected = prev_data;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Delay to match the CRC engine

	// Only read when a pending flag comes out with it
	always_ff @(posedge xgmii_rx_clk) begin
		if (xgmii_rx_bus.valid) begin
			fcs_pipe[0] <= fcs_expected;
			for (int i = 1; i < crc_latency; i++)
				fcs_pipe[i] <= fcs_pipe[i-1];
		end
	end

	// One flag per stage, so back to back frames can overlap
	always_ff @(posedge xgmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
			commit  <= 1'b0;
			drop    <= 1'b0;
		end else begin
			// Strobes last one clock
			commit <= 1'b0;
			drop   <= 1'b0;
			if (xgmii_rx_bus.valid) begin
				pending <= {pending[crc_latency-2:0], frame_event.frame_end};

				// Compare as the flag leaves the last stage
				if (pending[crc_latency-1]) begin
					if (fcs_pipe[crc_latency-1] == crc_value)
						commit <= 1'b1;
					else
						drop <= 1'b1;
				end

				// Abort drops now and cancels every compare in flight
				if (frame_event.frame_abort) begin
					pending <= '0;
					commit  <= 1'b0;
					drop    <= 1'b1;
				end
			end
		end
	end

endmodule

/* logic/xgmii_rx_mac.sv */
`timescale 1ns/1ps

module xgmii_rx_mac #(
	parameter int crc_latency = 2
) (
	input  logic                      xgmii_rx_clk,
	input  logic                      rst_n,
	input  xgmii_rx_pkg::xgmii_word_t xgmii_rx_bus,
	output xgmii_rx_pkg::eth_rx_bus_t rx_bus
);

	import xgmii_rx_pkg::*;

	eth_rx_bus_t  rx_stream;
	frame_event_t frame_event;
	logic         crc_restart;
	logic [31:0]  crc_value;
	logic         commit;
	logic         drop;

	// Framing, data register and byte counts
	rx_frame_fsm rx_frame_fsm_i (
		.xgmii_rx_clk (xgmii_rx_clk),
		.rst_n        (rst_n),
		.xgmii_rx_bus (xgmii_rx_bus),
		.rx_stream    (rx_stream),
		.frame_event  (frame_event),
		.crc_restart  (crc_restart)
	);

	// Runs on the same words the upper layer sees
	crc32_eth_x32 #(
		.crc_latency (crc_latency)
	) crc32_eth_x32_i (
		.xgmii_rx_clk (xgmii_rx_clk),
		.rst_n        (rst_n),
		.enable       (xgmii_rx_bus.valid),
		.restart      (crc_restart),
		.din          (rx_stream.data),
		.din_len      (rx_stream.bytes_valid),
		.crc_value    (crc_value)
	);

	// Same latency as the engine
	fcs_checker #(
		.crc_latency (crc_latency)
	) fcs_checker_i (
		.xgmii_rx_clk (xgmii_rx_clk),
		.rst_n        (rst_n),
		.xgmii_rx_bus (xgmii_rx_bus),
		.prev_data    (rx_stream.data),
		.frame_event  (frame_event),
		.crc_value    (crc_value),
		.commit       (commit),
		.drop         (drop)
	);

	// Stream fields from the FSM, verdict from the checker
	assign rx_bus = '{
		start:       rx_stream.start,
		data_valid:  rx_stream.data_valid,
		bytes_valid: rx_stream.bytes_valid,
		data:        rx_stream.data,
		commit:      commit,
		drop:        drop
	};

endmodule

/* testbench/xgmii_rx_mac_assert.sv */
`timescale 1ns/1ps

module xgmii_rx_mac_assert (
	input logic                      xgmii_rx_clk,
	input logic                      rst_n,
	input xgmii_rx_pkg::eth_rx_bus_t rx_bus,
	input xgmii_rx_pkg::rx_state_t   rx_state
);

	import xgmii_rx_pkg::*;

	// Failed assertions so far
	int fail_count = 0;

	////////////////////////////////////////////////////////////
	// Upper layer stream

	// Preamble word is never valid, so start stands alone
	start_alone: assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		!(rx_bus.start && rx_bus.data_valid))
	else begin
		$error("start and data_valid high in the same clock");
		fail_count++;
	end

	one_verdict: assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		!(rx_bus.commit && rx_bus.drop))
	else begin
		$error("commit and drop high in the same clock");
		fail_count++;
	end

	// A short word closes the frame and no data follows before the verdict
	short_word_last: assert property (@(posedge xgmii_rx_clk) disable iff (!rst_n)
		(rx_bus.data_valid && rx_bus.bytes_valid != 3'd4) |=>
			(!rx_bus.data_valid until (rx_bus.commit || rx_bus.drop)))
	else begin
		$error("data word after a short word before commit or drop");
		fail_count++;
	end

	////////////////////////////////////////////////////////////
	// Reset

	reset_quiet: assert property (@(posedge xgmii_rx_clk)
		!rst_n |-> !(rx_bus.start || rx_bus.data_valid || rx_bus.commit || rx_bus.drop))
	else begin
		$error("strobe high during reset");
		fail_count++;
	end

	reset_idle: assert property (@(posedge xgmii_rx_clk)
		$rose(rst_n) |-> (rx_state == state_idle))
	else begin
		$error("receive FSM not idle when reset ends");
		fail_count++;
	end

endmodule

bind xgmii_rx_mac xgmii_rx_mac_assert rx_mac_assert_i (
	.xgmii_rx_clk (xgmii_rx_clk),
	.rst_n        (rst_n),
	.rx_bus       (rx_bus),
	.rx_state     (rx_frame_fsm_i.rx_state)
);

/* testbench/tb_xgmii_rx_mac.sv */
`timescale 1ns/1ps

module tb_xgmii_rx_mac;

	import xgmii_rx_pkg::*;

	localparam int crc_latency    = 2;
	localparam int timeout_cycles = 300;

	logic        xgmii_rx_clk;
	logic        rst_n;
	xgmii_word_t xgmii_rx_bus;
	eth_rx_bus_t rx_bus;

	integer      seed = 32'he196;
	int          errors;
	bit          gaps_on;
	string       test_name;

	// One entry per frame that owes a commit or drop
	string       exp_name[$];
	bit          exp_commit[$];
	int          exp_len[$];
	logic [7:0]  exp_bytes[$];

	// Monitor state
	logic [7:0]  got_bytes[$];
	logic [2:0]  last_bv;
	bit          start_seen;
	int          start_count;
	int          word_count;
	int          verdict_count;

	xgmii_rx_mac #(
		.crc_latency (crc_latency)
	) xgmii_rx_mac_i (
		.xgmii_rx_clk (xgmii_rx_clk),
		.rst_n        (rst_n),
		.xgmii_rx_bus (xgmii_rx_bus),
		.rx_bus       (rx_bus)
	);

	// 125 MHz
	always #4 xgmii_rx_clk = ~xgmii_rx_clk;

	////////////////////////////////////////////////////////////
	// Reference CRC and checks

	// Bit at a time, LSB of each byte first
	function automatic logic [31:0] ref_crc32(input logic [7:0] data_bytes[$]);
		logic [31:0] crc;
		logic        feedback;
		crc = 32'hffffffff;
		foreach (data_bytes[i]) begin
			for (int b = 0; b < 8; b++) begin
				feedback = crc[0] ^ data_bytes[i][b];
				crc = crc >> 1;
				if (feedback)
					crc = crc ^ 32'hedb88320;
			end
		end
		return ~crc;
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual) else begin
			errors++;
			$display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// Verdict closes the oldest frame in flight
	task automatic judge_frame(input bit commit_seen);
		string      name;
		bit         want_commit;
		int         len;
		logic [7:0] exp_byte;
		name        = exp_name.pop_front();
		want_commit = exp_commit.pop_front();
		len         = exp_len.pop_front();
		check_value({name, " commit"}, want_commit, commit_seen);
		check_value({name, " start"}, 1, start_seen);
		start_seen = 1'b0;
		// Length 0 marks an aborted frame, payload not compared
		if (len > 0) begin
			check_value({name, " byte count"}, len, got_bytes.size());
			check_value({name, " last bytes_valid"}, (len % 4 == 0) ? 4 : len % 4, last_bv);
			for (int i = 0; i < len; i++) begin
				exp_byte = exp_bytes.pop_front();
				if (i < got_bytes.size())
					check_value($sformatf("%s byte %0d", name, i), exp_byte, got_bytes[i]);
			end
		end
	endtask

	// Outputs are stable mid cycle
	always @(negedge xgmii_rx_clk) begin
		if (rst_n) begin
			// Verdict first, a new start may share the clock
			if (rx_bus.commit || rx_bus.drop) begin
				verdict_count++;
				if (exp_commit.size() == 0) begin
					errors++;
					$display("Commit or drop with no frame in flight during %s", test_name);
				end else begin
					judge_frame(rx_bus.commit);
				end
			end
			if (rx_bus.start) begin
				start_count++;
				start_seen = 1'b1;
				got_bytes.delete();
			end
			if (rx_bus.data_valid) begin
				word_count++;
				last_bv = rx_bus.bytes_valid;
				for (int i = 0; i < rx_bus.bytes_valid; i++)
					got_bytes.push_back(rx_bus.data[31-8*i -: 8]);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus

	// Called 1 ns after an edge, returns 1 ns after the next one
	task automatic drive_word(input logic [3:0] ctl, input logic [31:0] data);
		if (gaps_on && ($random(seed) & 3) == 0) begin
			xgmii_rx_bus = '{valid: 1'b0, ctl: 4'hf, data: 32'h07070707};
			repeat (1 + ($random(seed) & 1)) @(posedge xgmii_rx_clk);
			#1;
		end
		xgmii_rx_bus = '{valid: 1'b1, ctl: ctl, data: data};
		@(posedge xgmii_rx_clk);
		#1;
	endtask

	task automatic send_idle(input int count);
		repeat (count) drive_word(4'hf, 32'h07070707);
	endtask

	// Mode 0 good, 1 bad FCS byte, 2 error character in body, 3 bad preamble
	task automatic send_frame(input int len, input int mode);
		logic [7:0]  stream[$];
		logic [31:0] fcs;
		logic [31:0] data;
		logic [3:0]  ctl;
		int          nwords;
		int          pos;
		for (int i = 0; i < len; i++)
			stream.push_back(8'($random(seed)));
		if (mode != 3) begin
			exp_name.push_back(test_name);
			exp_commit.push_back(mode == 0);
			exp_len.push_back((mode == 2) ? 0 : len);
			if (mode != 2)
				foreach (stream[i]) exp_bytes.push_back(stream[i]);
		end
		// FCS goes out low byte first
		fcs = ref_crc32(stream);
		for (int i = 0; i < 4; i++)
			stream.push_back(fcs[8*i +: 8]);
		if (mode == 1)
			stream[len + ($unsigned($random(seed)) % 4)] ^= 8'h5a;

		drive_word(4'b1000, {xgmii_ctl_start, 24'h555555});
		drive_word(4'b0000, (mode == 3) ? 32'h555555d4 : preamble_sfd_word);
		// Body, then the end character and idle fill
		nwords = (len + 4) / 4 + 1;
		for (int w = 0; w < nwords; w++) begin
			for (int lane = 3; lane >= 0; lane--) begin
				pos = 4 * w + 3 - lane;
				ctl[lane] = (pos >= len + 4);
				if (pos < len + 4)
					data[8*lane +: 8] = stream[pos];
				else
					data[8*lane +: 8] = (pos == len + 4) ? xgmii_ctl_end : xgmii_ctl_idle;
			end
			if (mode == 2 && w == nwords / 2) begin
				ctl[1]     = 1'b1;
				data[15:8] = xgmii_ctl_error;
				drive_word(ctl, data);
				// Drop must already be up
				check_value({test_name, " drop after error"}, 1, rx_bus.drop);
			end else begin
				drive_word(ctl, data);
			end
		end
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		xgmii_rx_bus = '{valid: 1'b1, ctl: 4'hf, data: 32'h07070707};
		while (exp_commit.size() != 0 && cycles < timeout_cycles) begin
			@(posedge xgmii_rx_clk);
			#1;
			cycles++;
		end
		if (exp_commit.size() != 0) begin
			errors++;
			$display("Timeout in %s: %0d frames never got commit or drop",
				test_name, exp_commit.size());
			exp_name.delete();
			exp_commit.delete();
			exp_len.delete();
			exp_bytes.delete();
		end
	endtask

	initial begin
		int starts_before;
		int words_before;
		int verdicts_before;
		int assert_errors;
		xgmii_rx_clk  = 1'b0;
		rst_n         = 1'b0;
		xgmii_rx_bus  = '{valid: 1'b0, ctl: 4'hf, data: 32'h07070707};
		errors        = 0;
		gaps_on       = 1'b0;
		start_seen    = 1'b0;
		start_count   = 0;
		word_count    = 0;
		verdict_count = 0;
		last_bv       = 3'd0;
		test_name     = "reset";
		repeat (2) @(posedge xgmii_rx_clk);
		#1;
		rst_n = 1'b1;
		send_idle(3);

		// Every end lane, random lengths
		test_name = "good_frame";
		for (int k = 0; k < 8; k++) begin
			send_frame(48 + 4 * ($unsigned($random(seed)) % 16) + k % 4, 0);
			send_idle(2);
		end
		wait_drain();

		test_name = "bad_fcs";
		for (int k = 0; k < 4; k++) begin
			send_frame(52 + k, 1);
			send_idle(2);
		end
		wait_drain();

		test_name = "error_char";
		send_frame(60, 2);
		send_idle(2);
		send_frame(63, 2);
		wait_drain();
		send_idle(crc_latency + 4);

		// Nothing at all may come out
		test_name       = "bad_preamble";
		starts_before   = start_count;
		words_before    = word_count;
		verdicts_before = verdict_count;
		send_frame(56, 3);
		send_idle(crc_latency + 4);
		check_value({test_name, " start count"}, starts_before, start_count);
		check_value({test_name, " data words"}, words_before, word_count);
		check_value({test_name, " verdicts"}, verdicts_before, verdict_count);

		// No idle between frames, overlapping compares
		test_name = "back_to_back";
		gaps_on   = 1'b1;
		for (int k = 0; k < 12; k++)
			send_frame(46 + k, (k % 4 == 1) ? 1 : ((k % 4 == 3) ? 2 : 0));
		gaps_on = 1'b0;
		wait_drain();
		send_idle(crc_latency + 4);

		assert_errors = xgmii_rx_mac_i.rx_mac_assert_i.fail_count;
		$display("Checks done: %0d scoreboard errors, %0d assertion errors",
			errors, assert_errors);
		if (errors == 0 && assert_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* all.f */
logic/xgmii_rx_pkg.sv
logic/rx_frame_fsm.sv
logic/crc32_eth_x32.sv
logic/fcs_checker.sv
logic/xgmii_rx_mac.sv
testbench/xgmii_rx_mac_assert.sv
testbench/tb_xgmii_rx_mac.sv
